// ==== common/mem_isa_pkg.sv ====
// ################################################
// RV64 load/store opcodes, access sizes and widths
// opcode values are internal to this pipeline only
// ################################################

package mem_isa_pkg;

  localparam int xlen   = 64;
  localparam int ridx_w = 5;
  localparam int inst_w = 32;

  // internal opcode, anything not listed below is no memory access
  typedef logic [7:0] opcode_t;

  localparam opcode_t inst_lb  = 8'h10;
  localparam opcode_t inst_lh  = 8'h11;
  localparam opcode_t inst_lw  = 8'h12;
  localparam opcode_t inst_ld  = 8'h13;
  localparam opcode_t inst_lbu = 8'h14;
  localparam opcode_t inst_lhu = 8'h15;
  localparam opcode_t inst_lwu = 8'h16;
  localparam opcode_t inst_sb  = 8'h18;
  localparam opcode_t inst_sh  = 8'h19;
  localparam opcode_t inst_sw  = 8'h1a;
  localparam opcode_t inst_sd  = 8'h1b;

  // byte count minus one
  typedef logic [2:0] size_t;

  localparam size_t size_b = 3'd0;
  localparam size_t size_h = 3'd1;
  localparam size_t size_w = 3'd3;
  localparam size_t size_d = 3'd7;

  // target of one access
  typedef enum logic [1:0] {
    chan_none = 2'd0,
    chan_mem  = 2'd1,
    chan_mmio = 2'd2
  } chan_t;

endpackage

// ==== common/mem_map_pkg.sv ====
// ################################################
// address map, regions decoded on bits 31:24 only
// ################################################

package mem_map_pkg;

  localparam logic [63:0] region_mask = 64'h0000_0000_ff00_0000;

  localparam logic [63:0] mem_base  = 64'h0000_0000_8000_0000;
  localparam logic [63:0] mmio_base = 64'h0000_0000_0200_0000;

  // timer registers, offsets within the mmio region
  localparam int off_w = 16;

  localparam logic [15:0] mtimecmp_off = 16'h4000;
  localparam logic [15:0] mtime_off    = 16'hbff8;

endpackage

// ==== design/mem_dcache_port.sv ====
// ################################################
// one request at a time, i_start ignored while busy
// ################################################

module mem_dcache_port (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          i_start,
  input  logic [mem_isa_pkg::xlen-1:0]  i_addr,
  input  logic                          i_ren,
  input  logic                          i_wen,
  input  mem_isa_pkg::size_t            i_size,
  input  logic [mem_isa_pkg::xlen-1:0]  i_wdata,
  output logic                          o_done,
  output logic [mem_isa_pkg::xlen-1:0]  o_rdata,
  output logic                          o_dcache_req,
  output logic [mem_isa_pkg::xlen-1:0]  o_dcache_addr,
  output logic                          o_dcache_op,
  output mem_isa_pkg::size_t            o_dcache_size,
  output logic [mem_isa_pkg::xlen-1:0]  o_dcache_wdata,
  input  logic                          i_dcache_ack,
  input  logic [mem_isa_pkg::xlen-1:0]  i_dcache_rdata
);

  typedef enum logic {
    st_idle,
    st_req
  } state_t;

  state_t                        state_q;
  logic                          done_q;
  logic                          ren_q;
  logic                          wen_q;
  logic [mem_isa_pkg::xlen-1:0]  addr_q;
  logic [mem_isa_pkg::xlen-1:0]  wdata_q;
  logic [mem_isa_pkg::xlen-1:0]  rdata_q;
  mem_isa_pkg::size_t            size_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (i_start) begin
            state_q <= st_req;
          end
        end
        st_req: begin
          if (i_dcache_ack) begin
            state_q <= st_idle;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // access fields stay stable for the whole request
  always_ff @(posedge clk) begin
    if (state_q == st_idle && i_start) begin
      addr_q  <= i_addr;
      ren_q   <= i_ren;
      wen_q   <= i_wen;
      size_q  <= i_size;
      wdata_q <= i_wdata;
    end
    if (state_q == st_req && i_dcache_ack && ren_q) begin
      rdata_q <= i_dcache_rdata;
    end
  end

  assign o_dcache_req   = (state_q == st_req);
  assign o_dcache_addr  = addr_q;
  // op high for a write
  assign o_dcache_op    = wen_q;
  assign o_dcache_size  = size_q;
  assign o_dcache_wdata = wdata_q;
  assign o_done         = done_q;
  assign o_rdata        = rdata_q;

endmodule

// ==== design/mem_clint.sv ====
// ################################################
// stores write all 64 bits whatever the access size
// irq is a level, cleared only by moving mtimecmp
// ################################################

module mem_clint (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          i_start,
  input  logic                          i_ren,
  input  logic                          i_wen,
  input  logic [mem_isa_pkg::xlen-1:0]  i_addr,
  input  logic [mem_isa_pkg::xlen-1:0]  i_wdata,
  output logic [mem_isa_pkg::xlen-1:0]  o_rdata,
  output logic                          o_timer_irq
);

  logic [mem_map_pkg::off_w-1:0] offset;
  logic                          hit_mtime;
  logic                          hit_cmp;
  logic                          wr;
  logic [mem_isa_pkg::xlen-1:0]  mtime_q;
  logic [mem_isa_pkg::xlen-1:0]  mtimecmp_q;
  logic [mem_isa_pkg::xlen-1:0]  rdata_q;
  logic                          irq_q;

  assign offset    = i_addr[mem_map_pkg::off_w-1:0];
  assign hit_mtime = (offset == mem_map_pkg::mtime_off);
  assign hit_cmp   = (offset == mem_map_pkg::mtimecmp_off);
  assign wr        = i_start & i_wen;

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_q      <= 1'b0;
    end else begin
      // a write to mtime replaces this cycle's increment
      if (wr && hit_mtime) begin
        mtime_q <= i_wdata;
      end else begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr && hit_cmp) begin
        mtimecmp_q <= i_wdata;
      end
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  // other offsets read as zero
  always_ff @(posedge clk) begin
    if (i_start && i_ren) begin
      if (hit_mtime) begin
        rdata_q <= mtime_q;
      end else if (hit_cmp) begin
        rdata_q <= mtimecmp_q;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign o_rdata     = rdata_q;
  assign o_timer_irq = irq_q;

endmodule

// ==== mem_stage/mem_access_decode.sv ====
// ################################################
// combinational, alignment of the address unchecked
// ################################################

module mem_access_decode (
  input  mem_isa_pkg::opcode_t          i_opcode,
  input  logic [mem_isa_pkg::xlen-1:0]  i_op_base,
  input  logic [mem_isa_pkg::xlen-1:0]  i_op_store,
  input  logic [mem_isa_pkg::xlen-1:0]  i_op_offset,
  output logic                          o_ren,
  output logic                          o_wen,
  output mem_isa_pkg::size_t            o_size,
  output logic [mem_isa_pkg::xlen-1:0]  o_addr,
  output logic [mem_isa_pkg::xlen-1:0]  o_wdata,
  output mem_isa_pkg::chan_t            o_chan
);

  logic [mem_isa_pkg::xlen-1:0] region;
  logic                         in_mem;
  logic                         in_mmio;

  assign o_addr  = i_op_base + i_op_offset;
  assign region  = o_addr & mem_map_pkg::region_mask;
  assign in_mem  = (region == mem_map_pkg::mem_base);
  assign in_mmio = (region == mem_map_pkg::mmio_base);

  always_comb begin
    o_ren  = 1'b0;
    o_wen  = 1'b0;
    o_size = mem_isa_pkg::size_b;
    case (i_opcode)
      mem_isa_pkg::inst_lb,
      mem_isa_pkg::inst_lbu: o_ren = 1'b1;
      mem_isa_pkg::inst_lh,
      mem_isa_pkg::inst_lhu: begin
        o_ren  = 1'b1;
        o_size = mem_isa_pkg::size_h;
      end
      mem_isa_pkg::inst_lw,
      mem_isa_pkg::inst_lwu: begin
        o_ren  = 1'b1;
        o_size = mem_isa_pkg::size_w;
      end
      mem_isa_pkg::inst_ld: begin
        o_ren  = 1'b1;
        o_size = mem_isa_pkg::size_d;
      end
      mem_isa_pkg::inst_sb: o_wen = 1'b1;
      mem_isa_pkg::inst_sh: begin
        o_wen  = 1'b1;
        o_size = mem_isa_pkg::size_h;
      end
      mem_isa_pkg::inst_sw: begin
        o_wen  = 1'b1;
        o_size = mem_isa_pkg::size_w;
      end
      mem_isa_pkg::inst_sd: begin
        o_wen  = 1'b1;
        o_size = mem_isa_pkg::size_d;
      end
      default: ;
    endcase
  end

  // only the low bytes of the store operand go out
  always_comb begin
    case (o_size)
      mem_isa_pkg::size_b: o_wdata = {{(mem_isa_pkg::xlen-8){1'b0}}, i_op_store[7:0]};
      mem_isa_pkg::size_h: o_wdata = {{(mem_isa_pkg::xlen-16){1'b0}}, i_op_store[15:0]};
      mem_isa_pkg::size_w: o_wdata = {{(mem_isa_pkg::xlen-32){1'b0}}, i_op_store[31:0]};
      default:             o_wdata = i_op_store;
    endcase
  end

  always_comb begin
    if (!(o_ren | o_wen)) begin
      o_chan = mem_isa_pkg::chan_none;
    end else if (in_mem) begin
      o_chan = mem_isa_pkg::chan_mem;
    end else if (in_mmio) begin
      o_chan = mem_isa_pkg::chan_mmio;
    end else begin
      // unmapped address
      o_chan = mem_isa_pkg::chan_none;
    end
  end

endmodule

// ==== mem_stage/mem_load_align.sv ====
// ################################################
// read data is taken from bit 0, not by address lane
// ################################################

module mem_load_align (
  input  mem_isa_pkg::opcode_t          i_opcode,
  input  mem_isa_pkg::chan_t            i_chan,
  input  logic [mem_isa_pkg::xlen-1:0]  i_rdata_mem,
  input  logic [mem_isa_pkg::xlen-1:0]  i_rdata_mmio,
  input  logic [mem_isa_pkg::xlen-1:0]  i_rd_wdata,
  output logic [mem_isa_pkg::xlen-1:0]  o_rd_wdata
);

  localparam int xl = mem_isa_pkg::xlen;

  logic [xl-1:0] rdata;

  // unmapped loads read as zero
  always_comb begin
    case (i_chan)
      mem_isa_pkg::chan_mem:  rdata = i_rdata_mem;
      mem_isa_pkg::chan_mmio: rdata = i_rdata_mmio;
      default:                rdata = '0;
    endcase
  end

  always_comb begin
    case (i_opcode)
      mem_isa_pkg::inst_lb:  o_rd_wdata = {{(xl-8){rdata[7]}}, rdata[7:0]};
      mem_isa_pkg::inst_lbu: o_rd_wdata = {{(xl-8){1'b0}}, rdata[7:0]};
      mem_isa_pkg::inst_lh:  o_rd_wdata = {{(xl-16){rdata[15]}}, rdata[15:0]};
      mem_isa_pkg::inst_lhu: o_rd_wdata = {{(xl-16){1'b0}}, rdata[15:0]};
      mem_isa_pkg::inst_lw:  o_rd_wdata = {{(xl-32){rdata[31]}}, rdata[31:0]};
      mem_isa_pkg::inst_lwu: o_rd_wdata = {{(xl-32){1'b0}}, rdata[31:0]};
      mem_isa_pkg::inst_ld:  o_rd_wdata = rdata;
      // stores and non-memory ops keep the execute result
      default:               o_rd_wdata = i_rd_wdata;
    endcase
  end

endmodule

// ==== mem_stage/mem_stage.sv ====
// ################################################
// one instruction in flight, no forwarding or traps
// none/mmio finish in one cycle, mem waits on dcache
// ################################################

module mem_stage (
  input  logic                             clk,
  input  logic                             rst,
  // execute side
  input  logic                             i_exec_req,
  output logic                             o_exec_ack,
  input  logic [mem_isa_pkg::xlen-1:0]     i_pc,
  input  logic [mem_isa_pkg::inst_w-1:0]   i_inst,
  input  logic [mem_isa_pkg::ridx_w-1:0]   i_rd,
  input  logic                             i_rd_wen,
  input  logic [mem_isa_pkg::xlen-1:0]     i_rd_wdata,
  input  mem_isa_pkg::opcode_t             i_opcode,
  input  logic [mem_isa_pkg::xlen-1:0]     i_op_base,
  input  logic [mem_isa_pkg::xlen-1:0]     i_op_store,
  input  logic [mem_isa_pkg::xlen-1:0]     i_op_offset,
  input  logic                             i_nocmt,
  input  logic                             i_skipcmt,
  // write-back side
  output logic                             o_done_req,
  input  logic                             i_done_ack,
  output logic [mem_isa_pkg::xlen-1:0]     o_pc,
  output logic [mem_isa_pkg::inst_w-1:0]   o_inst,
  output logic [mem_isa_pkg::ridx_w-1:0]   o_rd,
  output logic                             o_rd_wen,
  output logic [mem_isa_pkg::xlen-1:0]     o_rd_wdata,
  output logic                             o_nocmt,
  output logic                             o_skipcmt,
  // dcache side
  output logic                             o_dcache_req,
  output logic [mem_isa_pkg::xlen-1:0]     o_dcache_addr,
  output logic                             o_dcache_op,
  output mem_isa_pkg::size_t               o_dcache_size,
  output logic [mem_isa_pkg::xlen-1:0]     o_dcache_wdata,
  input  logic                             i_dcache_ack,
  input  logic [mem_isa_pkg::xlen-1:0]     i_dcache_rdata,
  // timer
  output logic                             o_timer_irq
);

  logic                          exec_hs;
  logic                          done_hs;
  logic                          busy_q;
  logic                          mem_done_q;
  mem_isa_pkg::chan_t            chan_q;
  mem_isa_pkg::opcode_t          opcode_q;
  logic [mem_isa_pkg::xlen-1:0]  rd_wdata_q;
  logic                          skipcmt_q;

  logic                          acc_ren;
  logic                          acc_wen;
  mem_isa_pkg::size_t            acc_size;
  logic [mem_isa_pkg::xlen-1:0]  acc_addr;
  logic [mem_isa_pkg::xlen-1:0]  acc_wdata;
  mem_isa_pkg::chan_t            acc_chan;

  logic                          dc_done;
  logic [mem_isa_pkg::xlen-1:0]  rdata_mem;
  logic [mem_isa_pkg::xlen-1:0]  rdata_mmio;

  assign o_exec_ack = ~busy_q;
  assign exec_hs    = i_exec_req & o_exec_ack;
  assign done_hs    = o_done_req & i_done_ack;

  // none and mmio results are ready as soon as they are held
  assign o_done_req = busy_q & ((chan_q != mem_isa_pkg::chan_mem) | dc_done | mem_done_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q     <= 1'b0;
      chan_q     <= mem_isa_pkg::chan_none;
      mem_done_q <= 1'b0;
    end else begin
      if (exec_hs) begin
        busy_q <= 1'b1;
        chan_q <= acc_chan;
      end else if (done_hs) begin
        busy_q <= 1'b0;
        chan_q <= mem_isa_pkg::chan_none;
      end
      // done pulse lasts one cycle, keep it until write-back takes it
      if (done_hs) begin
        mem_done_q <= 1'b0;
      end else if (dc_done) begin
        mem_done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (exec_hs) begin
      o_pc       <= i_pc;
      o_inst     <= i_inst;
      o_rd       <= i_rd;
      o_rd_wen   <= i_rd_wen;
      rd_wdata_q <= i_rd_wdata;
      opcode_q   <= i_opcode;
      o_nocmt    <= i_nocmt;
      skipcmt_q  <= i_skipcmt;
    end
  end

  // timer accesses are not visible to the reference model
  assign o_skipcmt = skipcmt_q | (chan_q == mem_isa_pkg::chan_mmio);

  mem_access_decode u_decode (
    .i_opcode    (i_opcode),
    .i_op_base   (i_op_base),
    .i_op_store  (i_op_store),
    .i_op_offset (i_op_offset),
    .o_ren       (acc_ren),
    .o_wen       (acc_wen),
    .o_size      (acc_size),
    .o_addr      (acc_addr),
    .o_wdata     (acc_wdata),
    .o_chan      (acc_chan)
  );

  mem_dcache_port u_dcache_port (
    .clk            (clk),
    .rst            (rst),
    .i_start        (exec_hs & (acc_chan == mem_isa_pkg::chan_mem)),
    .i_addr         (acc_addr),
    .i_ren          (acc_ren),
    .i_wen          (acc_wen),
    .i_size         (acc_size),
    .i_wdata        (acc_wdata),
    .o_done         (dc_done),
    .o_rdata        (rdata_mem),
    .o_dcache_req   (o_dcache_req),
    .o_dcache_addr  (o_dcache_addr),
    .o_dcache_op    (o_dcache_op),
    .o_dcache_size  (o_dcache_size),
    .o_dcache_wdata (o_dcache_wdata),
    .i_dcache_ack   (i_dcache_ack),
    .i_dcache_rdata (i_dcache_rdata)
  );

  mem_clint u_clint (
    .clk         (clk),
    .rst         (rst),
    .i_start     (exec_hs & (acc_chan == mem_isa_pkg::chan_mmio)),
    .i_ren       (acc_ren),
    .i_wen       (acc_wen),
    .i_addr      (acc_addr),
    .i_wdata     (acc_wdata),
    .o_rdata     (rdata_mmio),
    .o_timer_irq (o_timer_irq)
  );

  mem_load_align u_load_align (
    .i_opcode     (opcode_q),
    .i_chan       (chan_q),
    .i_rdata_mem  (rdata_mem),
    .i_rdata_mmio (rdata_mmio),
    .i_rd_wdata   (rd_wdata_q),
    .o_rd_wdata   (o_rd_wdata)
  );

endmodule

// ==== tests/tb_dcache_model.sv ====
// ##################################################
// 4 KiB of bytes, aliased over the whole mem region
// ack comes 0 to max_delay cycles after the request
// ##################################################

module tb_dcache_model #(
  parameter int max_delay = 4
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          i_req,
  input  logic [mem_isa_pkg::xlen-1:0]  i_addr,
  input  logic                          i_op,
  input  mem_isa_pkg::size_t            i_size,
  input  logic [mem_isa_pkg::xlen-1:0]  i_wdata,
  output logic                          o_ack,
  output logic [mem_isa_pkg::xlen-1:0]  o_rdata
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0]  mem [0:4095];
  integer      seed;
  int          wait_cnt;
  logic        busy;
  logic [11:0] idx;

  // reads return 8 bytes from the address, writes store size+1 bytes
  task automatic serve();
    for (logic [3:0] k = 0; k < 8; k++) begin
      idx = i_addr[11:0] + {8'd0, k};
      o_rdata[8*k +: 8] = mem[idx];
      if (i_op && k <= {1'b0, i_size}) begin
        mem[idx] = i_wdata[8*k +: 8];
      end
    end
  endtask

  initial begin
    seed     = 32'h9d5a;
    o_ack    = 1'b0;
    o_rdata  = '0;
    busy     = 1'b0;
    wait_cnt = 0;
    for (logic [12:0] a = 0; a < 4096; a++) begin
      mem[a[11:0]] = a[7:0] ^ a[11:4] ^ 8'h5a;
    end
    forever begin
      @(posedge clk);
      #1;
      if (rst || o_ack) begin
        o_ack = 1'b0;
        busy  = 1'b0;
      end else if (i_req) begin
        if (!busy) begin
          busy     = 1'b1;
          wait_cnt = $unsigned($random(seed)) % (max_delay + 1);
        end
        if (wait_cnt == 0) begin
          serve();
          o_ack = 1'b1;
        end else begin
          wait_cnt = wait_cnt - 1;
        end
      end
    end
  end

endmodule

// ==== tests/tb_mem_stage.sv ====
// ##################################################
// results checked in order against a shadow memory
// mtime is never read back, its value is not modelled
// ##################################################

module tb_mem_stage;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int xl        = mem_isa_pkg::xlen;
  localparam int max_delay = 4;
  localparam int n_rand    = 40;
  // two rounds of four stores, each followed by seven loads
  localparam int n_instr   = 64 + 4 + 2 + 4 + n_rand;
  localparam int timeout_cycles = n_instr * (max_delay + 12) + 100;
  localparam logic [xl-1:0] cmp_addr = mem_map_pkg::mmio_base | mem_map_pkg::mtimecmp_off;

  logic                          clk;
  logic                          rst;
  logic                          i_exec_req;
  logic                          o_exec_ack;
  logic [xl-1:0]                 i_pc;
  logic [mem_isa_pkg::inst_w-1:0] i_inst;
  logic [mem_isa_pkg::ridx_w-1:0] i_rd;
  logic                          i_rd_wen;
  logic [xl-1:0]                 i_rd_wdata;
  mem_isa_pkg::opcode_t          i_opcode;
  logic [xl-1:0]                 i_op_base;
  logic [xl-1:0]                 i_op_store;
  logic [xl-1:0]                 i_op_offset;
  logic                          i_nocmt;
  logic                          i_skipcmt;
  logic                          o_done_req;
  logic                          i_done_ack;
  logic [xl-1:0]                 o_pc;
  logic [mem_isa_pkg::inst_w-1:0] o_inst;
  logic [mem_isa_pkg::ridx_w-1:0] o_rd;
  logic                          o_rd_wen;
  logic [xl-1:0]                 o_rd_wdata;
  logic                          o_nocmt;
  logic                          o_skipcmt;
  logic                          o_dcache_req;
  logic [xl-1:0]                 o_dcache_addr;
  logic                          o_dcache_op;
  mem_isa_pkg::size_t            o_dcache_size;
  logic [xl-1:0]                 o_dcache_wdata;
  logic                          i_dcache_ack;
  logic [xl-1:0]                 i_dcache_rdata;
  logic                          o_timer_irq;

  logic [7:0]    shadow [0:4095];
  logic [xl-1:0] shadow_cmp;
  logic          irq_state;
  logic          bp_on;
  integer        seed;
  integer        bp_seed;
  logic [xl-1:0] pc;
  logic [xl-1:0] addr;
  int            dcache_count = 0;
  int            count_before;

  string         exp_name [$];
  logic [xl-1:0] exp_val [$];
  logic [xl-1:0] exp_pc [$];
  logic          exp_skip [$];
  logic          exp_irq [$];
  logic          exp_wen [$];
  logic          exp_nocmt [$];
  string         cur_name;
  logic [xl-1:0] cur_val;
  logic [xl-1:0] cur_pc;
  logic          cur_skip;
  logic          cur_irq;
  logic          cur_wen;
  logic          cur_nocmt;

  mem_stage UUT (
    .clk, .rst,
    .i_exec_req, .o_exec_ack, .i_pc, .i_inst, .i_rd, .i_rd_wen, .i_rd_wdata,
    .i_opcode, .i_op_base, .i_op_store, .i_op_offset, .i_nocmt, .i_skipcmt,
    .o_done_req, .i_done_ack, .o_pc, .o_inst, .o_rd, .o_rd_wen, .o_rd_wdata,
    .o_nocmt, .o_skipcmt,
    .o_dcache_req, .o_dcache_addr, .o_dcache_op, .o_dcache_size, .o_dcache_wdata,
    .i_dcache_ack, .i_dcache_rdata,
    .o_timer_irq
  );

  tb_dcache_model #(.max_delay(max_delay)) u_dcache_model (
    .clk, .rst,
    .i_req   (o_dcache_req),
    .i_addr  (o_dcache_addr),
    .i_op    (o_dcache_op),
    .i_size  (o_dcache_size),
    .i_wdata (o_dcache_wdata),
    .o_ack   (i_dcache_ack),
    .o_rdata (i_dcache_rdata)
  );

  task automatic fail_run(input string reason);
    $display("Something failed");
    $fatal(1, reason);
  endtask

  task automatic check_xlen(input string name, input logic [xl-1:0] expected,
                            input logic [xl-1:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      fail_run("value mismatch");
    end
  endtask

  task automatic check_inst(input string name,
                            input logic [mem_isa_pkg::inst_w-1:0] expected,
                            input logic [mem_isa_pkg::inst_w-1:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      fail_run("instruction mismatch");
    end
  endtask

  task automatic check_rd(input string name,
                          input logic [mem_isa_pkg::ridx_w-1:0] expected,
                          input logic [mem_isa_pkg::ridx_w-1:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      fail_run("register index mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERR %s expected %b actual %b", name, expected, actual);
      fail_run("flag mismatch");
    end
  endtask

  // loads 0..6, stores 7..10
  function automatic mem_isa_pkg::opcode_t op_by_index(input int i);
    case (i)
      0:       return mem_isa_pkg::inst_lb;
      1:       return mem_isa_pkg::inst_lbu;
      2:       return mem_isa_pkg::inst_lh;
      3:       return mem_isa_pkg::inst_lhu;
      4:       return mem_isa_pkg::inst_lw;
      5:       return mem_isa_pkg::inst_lwu;
      6:       return mem_isa_pkg::inst_ld;
      7:       return mem_isa_pkg::inst_sb;
      8:       return mem_isa_pkg::inst_sh;
      9:       return mem_isa_pkg::inst_sw;
      default: return mem_isa_pkg::inst_sd;
    endcase
  endfunction

  // returns {skip, write-back value}
  function automatic logic [xl:0] ref_result(input mem_isa_pkg::opcode_t op,
                                             input logic [xl-1:0] a,
                                             input logic [xl-1:0] rd_wdata,
                                             input logic skip);
    logic [4:0]    kind;
    logic [xl-1:0] region;
    logic [xl-1:0] raw;
    logic [xl-1:0] value;
    logic [11:0]   idx;
    logic          hit_mem;
    logic          hit_mmio;
    int            nbits;
    // kind is {load, store, signed, log2 bytes}
    case (op)
      mem_isa_pkg::inst_lb:  kind = 5'b10100;
      mem_isa_pkg::inst_lh:  kind = 5'b10101;
      mem_isa_pkg::inst_lw:  kind = 5'b10110;
      mem_isa_pkg::inst_ld:  kind = 5'b10111;
      mem_isa_pkg::inst_lbu: kind = 5'b10000;
      mem_isa_pkg::inst_lhu: kind = 5'b10001;
      mem_isa_pkg::inst_lwu: kind = 5'b10010;
      mem_isa_pkg::inst_sb,
      mem_isa_pkg::inst_sh,
      mem_isa_pkg::inst_sw,
      mem_isa_pkg::inst_sd:  kind = 5'b01000;
      default:               kind = 5'b00000;
    endcase
    region   = a & mem_map_pkg::region_mask;
    hit_mem  = (kind[4] | kind[3]) && (region == mem_map_pkg::mem_base);
    hit_mmio = (kind[4] | kind[3]) && (region == mem_map_pkg::mmio_base);
    raw = '0;
    if (hit_mem) begin
      for (logic [3:0] k = 0; k < 8; k++) begin
        idx = a[11:0] + {8'd0, k};
        raw[8*k +: 8] = shadow[idx];
      end
    end
    if (hit_mmio && a[15:0] == mem_map_pkg::mtimecmp_off) begin
      raw = shadow_cmp;
    end
    value = rd_wdata;
    if (kind[4]) begin
      nbits = 8 << kind[1:0];
      value = raw;
      for (int b = nbits; b < xl; b++) begin
        value[b] = kind[2] & raw[nbits-1];
      end
    end
    return {hit_mmio | skip, value};
  endfunction

  task automatic apply_store(input mem_isa_pkg::opcode_t op, input logic [xl-1:0] a,
                             input logic [xl-1:0] data);
    logic [xl-1:0] region;
    logic [11:0]   idx;
    int            nbytes;
    case (op)
      mem_isa_pkg::inst_sb: nbytes = 1;
      mem_isa_pkg::inst_sh: nbytes = 2;
      mem_isa_pkg::inst_sw: nbytes = 4;
      mem_isa_pkg::inst_sd: nbytes = 8;
      default:              nbytes = 0;
    endcase
    region = a & mem_map_pkg::region_mask;
    if (nbytes != 0 && region == mem_map_pkg::mem_base) begin
      for (int k = 0; k < nbytes; k++) begin
        idx = a[11:0] + k[11:0];
        shadow[idx] = data[8*k +: 8];
      end
    end else if (nbytes == 8 && region == mem_map_pkg::mmio_base &&
                 a[15:0] == mem_map_pkg::mtimecmp_off) begin
      shadow_cmp = data;
      // mtime stays far below every nonzero compare value used here
      irq_state  = (data == '0);
    end
  endtask

  // starts 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic issue(input string label, input mem_isa_pkg::opcode_t op,
                       input logic [xl-1:0] a, input logic [xl-1:0] store,
                       input logic timed);
    logic [xl-1:0] offset;
    logic [xl-1:0] wdata;
    logic [xl:0]   res;
    offset      = {32'd0, $random(seed)} & 64'h7f8;
    wdata       = {$random(seed), $random(seed)};
    i_rd_wen    = ($random(seed) & 1) != 0;
    i_nocmt     = ($random(seed) & 1) != 0;
    i_skipcmt   = ($random(seed) & 1) != 0;
    res         = ref_result(op, a, wdata, i_skipcmt);
    i_pc        = pc;
    i_inst      = pc[31:0];
    i_rd        = pc[6:2];
    i_rd_wdata  = wdata;
    i_opcode    = op;
    i_op_base   = a - offset;
    i_op_offset = offset;
    i_op_store  = store;
    i_exec_req  = 1'b1;
    while (!o_exec_ack) begin
      @(posedge clk);
      #1;
    end
    exp_name.push_back($sformatf("%s op %h pc %h", label, op, pc));
    exp_val.push_back(res[xl-1:0]);
    exp_pc.push_back(pc);
    exp_skip.push_back(res[xl]);
    exp_irq.push_back(irq_state);
    exp_wen.push_back(i_rd_wen);
    exp_nocmt.push_back(i_nocmt);
    @(posedge clk);
    #1;
    i_exec_req = 1'b0;
    if (timed) begin
      check_bit({label, " done latency"}, 1'b1, o_done_req);
    end
    apply_store(op, a, store);
    pc = pc + 4;
  endtask

  task automatic drain();
    while (exp_val.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  function automatic logic [xl-1:0] rand_mem_addr();
    return mem_map_pkg::mem_base | ({32'd0, $random(seed)} & 64'hff8);
  endfunction

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // write-back back-pressure
  initial begin
    i_done_ack = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      if (bp_on) begin
        i_done_ack = ($random(bp_seed) & 1) != 0;
      end else begin
        i_done_ack = 1'b1;
      end
    end
  end

  // cycles with a dcache request pending
  always @(negedge clk) begin
    if (o_dcache_req) begin
      dcache_count++;
    end
  end

  always @(negedge clk) begin
    if (!rst && o_done_req && i_done_ack) begin
      if (exp_val.size() == 0) begin
        $display("write-back arrived with no instruction outstanding");
        fail_run("unexpected write-back");
      end else begin
        cur_name  = exp_name.pop_front();
        cur_val   = exp_val.pop_front();
        cur_pc    = exp_pc.pop_front();
        cur_skip  = exp_skip.pop_front();
        cur_irq   = exp_irq.pop_front();
        cur_wen   = exp_wen.pop_front();
        cur_nocmt = exp_nocmt.pop_front();
        check_xlen({cur_name, " rd_wdata"}, cur_val, o_rd_wdata);
        check_xlen({cur_name, " pc"}, cur_pc, o_pc);
        check_inst({cur_name, " inst"}, cur_pc[31:0], o_inst);
        check_rd({cur_name, " rd"}, cur_pc[6:2], o_rd);
        check_bit({cur_name, " rd_wen"}, cur_wen, o_rd_wen);
        check_bit({cur_name, " nocmt"}, cur_nocmt, o_nocmt);
        check_bit({cur_name, " skipcmt"}, cur_skip, o_skipcmt);
        check_bit({cur_name, " timer irq"}, cur_irq, o_timer_irq);
      end
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("stage stopped making progress within %0d cycles", timeout_cycles);
    fail_run("watchdog timeout");
  end

  initial begin
    seed        = 32'h9d5a;
    bp_seed     = seed + 1;
    bp_on       = 1'b0;
    irq_state   = 1'b0;
    shadow_cmp  = '1;
    pc          = 64'h0000_0000_8000_0000;
    rst         = 1'b1;
    i_exec_req  = 1'b0;
    i_pc        = '0;
    i_inst      = '0;
    i_rd        = '0;
    i_rd_wen    = 1'b0;
    i_rd_wdata  = '0;
    i_opcode    = '0;
    i_op_base   = '0;
    i_op_store  = '0;
    i_op_offset = '0;
    i_nocmt     = 1'b0;
    i_skipcmt   = 1'b0;
    for (logic [12:0] a = 0; a < 4096; a++) begin
      shadow[a[11:0]] = a[7:0] ^ a[11:4] ^ 8'h5a;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // stores of each size, then every load opcode
    for (int r = 0; r < 2; r++) begin
      for (int s = 0; s < 4; s++) begin
        addr = rand_mem_addr();
        issue("mem store", op_by_index(7 + s), addr, {$random(seed), $random(seed)}, 1'b0);
        for (int l = 0; l < 7; l++) begin
          issue("mem load", op_by_index(l), addr, '0, 1'b0);
        end
      end
    end
    drain();

    // no access, no dcache traffic, none channel done one cycle after accept
    count_before = dcache_count;
    issue("no access", 8'h00, rand_mem_addr(), '0, 1'b1);
    issue("no access", 8'h33, mem_map_pkg::mem_base, '0, 1'b1);
    issue("unmapped", mem_isa_pkg::inst_ld, 64'h0000_0000_4000_0000, '0, 1'b1);
    issue("unmapped", mem_isa_pkg::inst_lb, 64'h0000_0000_0000_1000, '0, 1'b1);
    drain();
    check_xlen("no dcache", 64'(count_before), 64'(dcache_count));

    // mtimecmp write and read back
    issue("timer", mem_isa_pkg::inst_sd, cmp_addr, 64'h7fff_0000_1234_5678, 1'b0);
    issue("timer", mem_isa_pkg::inst_ld, cmp_addr, '0, 1'b0);

    // irq level follows mtimecmp
    issue("irq", mem_isa_pkg::inst_sd, cmp_addr, '0, 1'b0);
    issue("irq", 8'h00, '0, '0, 1'b0);
    issue("irq", mem_isa_pkg::inst_sd, cmp_addr, '1, 1'b0);
    issue("irq", 8'h00, '0, '0, 1'b0);
    drain();

    // random traffic under back-pressure
    bp_on = 1'b1;
    for (int i = 0; i < n_rand; i++) begin
      issue("random", op_by_index($unsigned($random(seed)) % 11), rand_mem_addr(),
            {$random(seed), $random(seed)}, 1'b0);
    end
    drain();
    bp_on = 1'b0;

    $display("Everything OK");
    $finish;
  end

endmodule

// ==== mem_stage.f ====
common/mem_isa_pkg.sv
common/mem_map_pkg.sv
design/mem_dcache_port.sv
design/mem_clint.sv
mem_stage/mem_access_decode.sv
mem_stage/mem_load_align.sv
mem_stage/mem_stage.sv
tests/tb_dcache_model.sv
tests/tb_mem_stage.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - common/mem_isa_pkg.sv
  - common/mem_map_pkg.sv
  - design/mem_dcache_port.sv
  - design/mem_clint.sv
  - mem_stage/mem_access_decode.sv
  - mem_stage/mem_load_align.sv
  - mem_stage/mem_stage.sv
  - target: test
    files:
      - tests/tb_dcache_model.sv
      - tests/tb_mem_stage.sv
